// File: include/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// data word width
`define XLEN 32

// register index width for 32 architectural registers
`define REG_ADDR_W 5

`define DMEM_WORDS 64 // data memory depth in words

`endif

// File: verilog/riscDataPkg.sv
`default_nettype none

`include "riscv_defs.svh"

package riscDataPkg;

    // register value, pc, immediate or alu result
    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;  // bit 0 selects bne over beq

endpackage

`default_nettype wire

// File: verilog/riscCtrlPkg.sv
`default_nettype none

package riscCtrlPkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1, // also used for branch compare
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } aluOp_t;

    // writeback result source
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrc_t;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0, // no hazard
        FWD_WB  = 2'd1, // two positions ahead
        FWD_MEM = 2'd2  // one position ahead
    } fwdSel_t;

endpackage

`default_nettype wire

// File: verilog/regFile.sv
`default_nettype none

`include "riscv_defs.svh"

module regFile import riscDataPkg::*; (
    input  wire           clk,
    input  wire           rstN_i,
    input  wire regAddr_t rs1Addr_i,
    input  wire regAddr_t rs2Addr_i,
    input  wire regAddr_t rdAddr_i,
    input  wire           writeEn_i,
    input  wire word_t    writeData_i,
    output word_t         rs1Data_o,
    output word_t         rs2Data_o,
    output word_t         a0_o
);

    word_t regs [1:(2**`REG_ADDR_W)-1]; // x0 not stored

    // same-cycle write shows up on the read port
    function automatic word_t readPort(regAddr_t addr);
        if (addr == '0)
            return '0;
        else if (writeEn_i && (addr == rdAddr_i))
            return writeData_i;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < 2**`REG_ADDR_W; i++)
                regs[i] <= '0;
        end else if (writeEn_i && (rdAddr_i != '0)) begin
            regs[rdAddr_i] <= writeData_i;
        end
    end

    always_comb begin
        rs1Data_o = readPort(rs1Addr_i);
        rs2Data_o = readPort(rs2Addr_i);
    end

    assign a0_o = regs[10]; // debug view without bypass

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
`default_nettype none

module aluUnit
    import riscDataPkg::*;
    import riscCtrlPkg::*;
(
    input  wire aluOp_t aluControl_i,
    input  wire word_t  srcA_i,
    input  wire word_t  srcB_i,
    output word_t       result_o,
    output logic        zero_o
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = srcB_i[4:0];
    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (aluControl_i)
            ALU_ADD: result_o = srcA_i + srcB_i;
            ALU_SUB: result_o = srcA_i - srcB_i;
            ALU_AND: result_o = srcA_i & srcB_i;
            ALU_OR:  result_o = srcA_i | srcB_i;
            ALU_XOR: result_o = srcA_i ^ srcB_i;
            ALU_SLT: begin
                result_o    = '0;
                result_o[0] = lessThan; // signed compare
            end
            ALU_SLL: result_o = srcA_i << shamt;
            ALU_SRL: result_o = srcA_i >> shamt;
            default: result_o = '0;
        endcase
    end

    // branches compare with sub
    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// File: verilog/decodeExecReg.sv
`default_nettype none

module decodeExecReg
    import riscDataPkg::*;
    import riscCtrlPkg::*;
(
    input  wire             clk,
    input  wire             rstN_i,
    input  wire             en_i,
    input  wire             flush_i,
    input  wire word_t      pcD_i,
    input  wire word_t      pcPlus4D_i,
    input  wire word_t      rd1D_i,
    input  wire word_t      rd2D_i,
    input  wire regAddr_t   rs1D_i,
    input  wire regAddr_t   rs2D_i,
    input  wire regAddr_t   rdD_i,
    input  wire word_t      extImmD_i,
    input  wire opcode_t    opcodeD_i,
    input  wire funct3_t    funct3D_i,
    input  wire             regWriteD_i,
    input  wire             memWriteD_i,
    input  wire resultSrc_t resultSrcD_i,
    input  wire aluOp_t     aluControlD_i,
    input  wire             aluSrcD_i,
    input  wire             branchD_i,
    input  wire             jumpD_i,
    output word_t           pcE_o,
    output word_t           pcPlus4E_o,
    output word_t           rd1E_o,
    output word_t           rd2E_o,
    output regAddr_t        rs1E_o,
    output regAddr_t        rs2E_o,
    output regAddr_t        rdE_o,
    output word_t           extImmE_o,
    output opcode_t         opcodeE_o,
    output funct3_t         funct3E_o,
    output logic            regWriteE_o,
    output logic            memWriteE_o,
    output resultSrc_t      resultSrcE_o,
    output aluOp_t          aluControlE_o,
    output logic            aluSrcE_o,
    output logic            branchE_o,
    output logic            jumpE_o
);

    // control and register tags load a bubble on reset or flush
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            rs1E_o        <= '0;
            rs2E_o        <= '0;
            rdE_o         <= '0;
            regWriteE_o   <= 1'b0;
            memWriteE_o   <= 1'b0;
            resultSrcE_o  <= RES_ALU;
            aluControlE_o <= ALU_ADD;
            aluSrcE_o     <= 1'b0;
            branchE_o     <= 1'b0;
            jumpE_o       <= 1'b0;
        end else if (flush_i) begin // wins over enable
            rs1E_o        <= '0;
            rs2E_o        <= '0;
            rdE_o         <= '0;
            regWriteE_o   <= 1'b0;
            memWriteE_o   <= 1'b0;
            resultSrcE_o  <= RES_ALU;
            aluControlE_o <= ALU_ADD;
            aluSrcE_o     <= 1'b0;
            branchE_o     <= 1'b0;
            jumpE_o       <= 1'b0;
        end else if (en_i) begin
            rs1E_o        <= rs1D_i;
            rs2E_o        <= rs2D_i;
            rdE_o         <= rdD_i;
            regWriteE_o   <= regWriteD_i;
            memWriteE_o   <= memWriteD_i;
            resultSrcE_o  <= resultSrcD_i;
            aluControlE_o <= aluControlD_i;
            aluSrcE_o     <= aluSrcD_i;
            branchE_o     <= branchD_i;
            jumpE_o       <= jumpD_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin // held while stalled
            pcE_o      <= pcD_i;
            pcPlus4E_o <= pcPlus4D_i;
            rd1E_o     <= rd1D_i;
            rd2E_o     <= rd2D_i;
            extImmE_o  <= extImmD_i;
            opcodeE_o  <= opcodeD_i;
            funct3E_o  <= funct3D_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`default_nettype none

module executeStage
    import riscDataPkg::*;
    import riscCtrlPkg::*;
(
    input  wire word_t   rd1E_i,
    input  wire word_t   rd2E_i,
    input  wire word_t   pcE_i,
    input  wire word_t   extImmE_i,
    input  wire fwdSel_t fwdAE_i,
    input  wire fwdSel_t fwdBE_i,
    input  wire word_t   resultW_i,
    input  wire word_t   aluResultM_i,
    input  wire aluOp_t  aluControlE_i,
    input  wire          aluSrcE_i,
    input  wire          branchE_i,
    input  wire          jumpE_i,
    input  wire funct3_t funct3E_i,
    output word_t        aluResultE_o,
    output word_t        writeDataE_o,
    output word_t        pcTargetE_o,
    output logic         zeroE_o,
    output logic         pcSrcE_o
);

    word_t srcAE;
    word_t srcBE;
    logic  branchCond;

    function automatic word_t fwdMux(fwdSel_t sel, word_t regData);
        case (sel)
            FWD_WB:  return resultW_i;
            FWD_MEM: return aluResultM_i;
            default: return regData;
        endcase
    endfunction

    always_comb begin
        srcAE        = fwdMux(fwdAE_i, rd1E_i);
        writeDataE_o = fwdMux(fwdBE_i, rd2E_i); // store data sees forwarding too
    end

    assign srcBE = aluSrcE_i ? extImmE_i : writeDataE_o;

    aluUnit alu (
        .aluControl_i (aluControlE_i),
        .srcA_i       (srcAE),
        .srcB_i       (srcBE),
        .result_o     (aluResultE_o),
        .zero_o       (zeroE_o)
    );

    assign pcTargetE_o = pcE_i + extImmE_i;

    // funct3[0] flips beq into bne
    assign branchCond = zeroE_o ^ funct3E_i[0];
    assign pcSrcE_o   = (branchE_i & branchCond) | jumpE_i;

endmodule

`default_nettype wire

// File: verilog/memStage.sv
`default_nettype none

`include "riscv_defs.svh"

module memStage
    import riscDataPkg::*;
    import riscCtrlPkg::*;
(
    input  wire             clk,
    input  wire             rstN_i,
    input  wire word_t      aluResultE_i,
    input  wire word_t      writeDataE_i,
    input  wire word_t      pcPlus4E_i,
    input  wire regAddr_t   rdE_i,
    input  wire             regWriteE_i,
    input  wire             memWriteE_i,
    input  wire resultSrc_t resultSrcE_i,
    output word_t           aluResultM_o,
    output regAddr_t        rdM_o,
    output regAddr_t        rdW_o,
    output logic            regWriteW_o,
    output word_t           resultW_o
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    word_t      dmem [`DMEM_WORDS];
    word_t      writeDataM, pcPlus4M, readDataM;
    logic       regWriteM, memWriteM;
    resultSrc_t resultSrcM, resultSrcW;
    word_t      aluResultW, readDataW, pcPlus4W;
    logic [IDX_W-1:0] wordIdx;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            rdM_o       <= '0;
            regWriteM   <= 1'b0;
            memWriteM   <= 1'b0;
            resultSrcM  <= RES_ALU;
            rdW_o       <= '0;
            regWriteW_o <= 1'b0;
            resultSrcW  <= RES_ALU;
        end else begin
            rdM_o       <= rdE_i;
            regWriteM   <= regWriteE_i;
            memWriteM   <= memWriteE_i;
            resultSrcM  <= resultSrcE_i;
            rdW_o       <= rdM_o;
            regWriteW_o <= regWriteM;
            resultSrcW  <= resultSrcM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM_o <= aluResultE_i;
        writeDataM   <= writeDataE_i;
        pcPlus4M     <= pcPlus4E_i;
        aluResultW   <= aluResultM_o;
        readDataW    <= readDataM;
        pcPlus4W     <= pcPlus4M;
    end

    assign wordIdx = aluResultM_o[IDX_W+1:2]; // wraps at the depth

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (memWriteM) begin
            dmem[wordIdx] <= writeDataM;
        end
    end

    assign readDataM = dmem[wordIdx];

    always_comb begin
        case (resultSrcW)
            RES_MEM: resultW_o = readDataW;
            RES_PC4: resultW_o = pcPlus4W; // jal link
            default: resultW_o = aluResultW;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/execPipeTop.sv
`default_nettype none

module execPipeTop
    import riscDataPkg::*;
    import riscCtrlPkg::*;
(
    input  wire             clk,
    input  wire             rstN_i,
    input  wire word_t      pcD_i,
    input  wire regAddr_t   rs1D_i,
    input  wire regAddr_t   rs2D_i,
    input  wire regAddr_t   rdD_i,
    input  wire word_t      extImmD_i,
    input  wire opcode_t    opcodeD_i,
    input  wire funct3_t    funct3D_i,
    input  wire             regWriteD_i,
    input  wire             memWriteD_i,
    input  wire resultSrc_t resultSrcD_i,
    input  wire aluOp_t     aluControlD_i,
    input  wire             aluSrcD_i,
    input  wire             branchD_i,
    input  wire             jumpD_i,
    input  wire             enD_i,
    input  wire             flushE_i,
    input  wire fwdSel_t    fwdAE_i,
    input  wire fwdSel_t    fwdBE_i,
    output regAddr_t        Rs1E_o,
    output regAddr_t        Rs2E_o,
    output regAddr_t        RdE_o,
    output regAddr_t        RdM_o,
    output regAddr_t        RdW_o,
    output word_t           pcTargetE_o,
    output logic            pcSrcE_o,
    output logic            zeroE_o,
    output word_t           a0_o
);

    word_t      rd1D, rd2D, pcPlus4D;
    word_t      pcE, pcPlus4E, rd1E, rd2E, extImmE;
    funct3_t    funct3E;
    logic       regWriteE, memWriteE, aluSrcE, branchE, jumpE;
    resultSrc_t resultSrcE;
    aluOp_t     aluControlE;
    word_t      aluResultE, writeDataE, aluResultM, resultW;
    logic       regWriteW;

    assign pcPlus4D = pcD_i + 32'd4;

    regFile regs (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .rs1Addr_i   (rs1D_i),
        .rs2Addr_i   (rs2D_i),
        .rdAddr_i    (RdW_o),
        .writeEn_i   (regWriteW),
        .writeData_i (resultW),
        .rs1Data_o   (rd1D),
        .rs2Data_o   (rd2D),
        .a0_o        (a0_o)
    );

    decodeExecReg deReg (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .en_i          (enD_i),
        .flush_i       (flushE_i),
        .pcD_i         (pcD_i),
        .pcPlus4D_i    (pcPlus4D),
        .rd1D_i        (rd1D),
        .rd2D_i        (rd2D),
        .rs1D_i        (rs1D_i),
        .rs2D_i        (rs2D_i),
        .rdD_i         (rdD_i),
        .extImmD_i     (extImmD_i),
        .opcodeD_i     (opcodeD_i),
        .funct3D_i     (funct3D_i),
        .regWriteD_i   (regWriteD_i),
        .memWriteD_i   (memWriteD_i),
        .resultSrcD_i  (resultSrcD_i),
        .aluControlD_i (aluControlD_i),
        .aluSrcD_i     (aluSrcD_i),
        .branchD_i     (branchD_i),
        .jumpD_i       (jumpD_i),
        .pcE_o         (pcE),
        .pcPlus4E_o    (pcPlus4E),
        .rd1E_o        (rd1E),
        .rd2E_o        (rd2E),
        .rs1E_o        (Rs1E_o),
        .rs2E_o        (Rs2E_o),
        .rdE_o         (RdE_o),
        .extImmE_o     (extImmE),
        .opcodeE_o     (),           // no jalr decode in execute yet
        .funct3E_o     (funct3E),
        .regWriteE_o   (regWriteE),
        .memWriteE_o   (memWriteE),
        .resultSrcE_o  (resultSrcE),
        .aluControlE_o (aluControlE),
        .aluSrcE_o     (aluSrcE),
        .branchE_o     (branchE),
        .jumpE_o       (jumpE)
    );

    executeStage exec (
        .rd1E_i        (rd1E),
        .rd2E_i        (rd2E),
        .pcE_i         (pcE),
        .extImmE_i     (extImmE),
        .fwdAE_i       (fwdAE_i),
        .fwdBE_i       (fwdBE_i),
        .resultW_i     (resultW),
        .aluResultM_i  (aluResultM),
        .aluControlE_i (aluControlE),
        .aluSrcE_i     (aluSrcE),
        .branchE_i     (branchE),
        .jumpE_i       (jumpE),
        .funct3E_i     (funct3E),
        .aluResultE_o  (aluResultE),
        .writeDataE_o  (writeDataE),
        .pcTargetE_o   (pcTargetE_o),
        .zeroE_o       (zeroE_o),
        .pcSrcE_o      (pcSrcE_o)
    );

    memStage mem (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .aluResultE_i (aluResultE),
        .writeDataE_i (writeDataE),
        .pcPlus4E_i   (pcPlus4E),
        .rdE_i        (RdE_o),
        .regWriteE_i  (regWriteE),
        .memWriteE_i  (memWriteE),
        .resultSrcE_i (resultSrcE),
        .aluResultM_o (aluResultM),
        .rdM_o        (RdM_o),
        .rdW_o        (RdW_o),
        .regWriteW_o  (regWriteW),
        .resultW_o    (resultW)
    );

endmodule

`default_nettype wire

// File: tests/execPipe_chk.sv
`default_nettype none

module execPipe_chk import riscDataPkg::*; (
    input wire           clk,
    input wire           rstN_i,
    input wire           pcSrcE_o,
    input wire regAddr_t RdE_o,
    input wire regAddr_t RdM_o,
    input wire regAddr_t RdW_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // no redirect while the pipe is held in reset
    noRedirectInReset: assert property (@(posedge clk) !rstN_i |-> !pcSrcE_o)
        else $error("pcSrcE_o high during reset");

    rdTagEtoM: assert property (@(posedge clk) disable iff (!rstN_i)
        RdM_o == $past(RdE_o))
        else $error("RdM_o does not follow RdE_o");

    rdTagMtoW: assert property (@(posedge clk) disable iff (!rstN_i)
        RdW_o == $past(RdM_o))
        else $error("RdW_o does not follow RdM_o");

endmodule

bind execPipeTop execPipe_chk chk (
    .clk      (clk),
    .rstN_i   (rstN_i),
    .pcSrcE_o (pcSrcE_o),
    .RdE_o    (RdE_o),
    .RdM_o    (RdM_o),
    .RdW_o    (RdW_o)
);

`default_nettype wire

// File: tests/execPipeTb.sv
`default_nettype none

`include "riscv_defs.svh"

module execPipeTb import riscDataPkg::*; import riscCtrlPkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    typedef struct {
        word_t      pc;
        regAddr_t   rs1;
        regAddr_t   rs2;
        regAddr_t   rd;
        word_t      imm;
        aluOp_t     alu;
        logic       aluSrc;
        logic       regW;
        logic       memW;
        resultSrc_t res;
        logic       br;
        logic       jmp;
        funct3_t    f3;
        fwdSel_t    fa;
        fwdSel_t    fb;
        logic       en;
        logic       flush;
        logic       expT;
    } row_t;

    logic clk, rstN_i, regWriteD_i, memWriteD_i, aluSrcD_i, branchD_i, jumpD_i;
    logic enD_i, flushE_i, pcSrcE_o, zeroE_o;
    word_t pcD_i, extImmD_i, pcTargetE_o, a0_o;
    regAddr_t rs1D_i, rs2D_i, rdD_i, Rs1E_o, Rs2E_o, RdE_o, RdM_o, RdW_o;
    opcode_t opcodeD_i;
    funct3_t funct3D_i;
    resultSrc_t resultSrcD_i;
    aluOp_t aluControlD_i;
    fwdSel_t fwdAE_i, fwdBE_i;

    row_t rows[$];
    integer seed = 35416;
    int cycles = 0;
    int cycleLimit = 1000;

    // reference pipeline state
    word_t refRegs [32];
    word_t refMem [`DMEM_WORDS];
    logic eValid, eRegW, eMemW, eAluSrc, eBr, eJmp, eExp;
    word_t ePc, ePc4, eRd1, eRd2, eImm;
    regAddr_t eRs1, eRs2, eRd, mRd, wRd;
    funct3_t eF3;
    resultSrc_t eRes, mRes, wRes;
    aluOp_t eAlu;
    fwdSel_t eFwdA, eFwdB;
    word_t mAluR, mWd, mPc4, wAlu, wRead, wPc4;
    logic mRegW, mMemW, wRegW;
    word_t xAlu, xWd, xTarget;
    logic xZero, xTaken;

    execPipeTop UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic checkVal(string name, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("FAIL time %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic addRow(word_t pc, regAddr_t rs1, regAddr_t rs2, regAddr_t rd, word_t imm,
                          aluOp_t alu, logic aluSrc, logic regW, logic memW, resultSrc_t res,
                          logic br, logic jmp, funct3_t f3, logic en, logic flush, logic expT);
        row_t r;
        r = '{pc, rs1, rs2, rd, imm, alu, aluSrc, regW, memW, res, br, jmp, f3,
              FWD_RF, FWD_RF, en, flush, expT};
        rows.push_back(r);
    endtask

    task automatic opRow(aluOp_t alu, regAddr_t rd, regAddr_t rs1, regAddr_t rs2, word_t imm,
                         logic aluSrc, fwdSel_t fa, fwdSel_t fb);
        addRow(32'(rows.size() * 4), rs1, rs2, rd, imm, alu, aluSrc, 1, 0, RES_ALU, 0, 0, 0,
               1, 0, 0);
        rows[rows.size() - 1].fa = fa;
        rows[rows.size() - 1].fb = fb;
    endtask

    task automatic nopRow(logic en);
        addRow(32'(rows.size() * 4), 0, 0, 0, 0, ALU_ADD, 0, 0, 0, RES_ALU, 0, 0, 0, en, 0, 0);
    endtask

    function automatic word_t aluRef(aluOp_t op, word_t a, word_t b);
        case (op)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return a + b;
        endcase
    endfunction

    function automatic word_t wResult();
        if (wRes == RES_MEM)
            return wRead;
        else if (wRes == RES_PC4)
            return wPc4;
        return wAlu;
    endfunction

    function automatic word_t rfRead(regAddr_t a);
        if (a == 0)
            return 0;
        else if (wRegW && a == wRd)
            return wResult(); // writeback bypass
        return refRegs[a];
    endfunction

    function automatic int memIdx(word_t a);
        return int'(a[IDX_W+1:2]);
    endfunction

    function automatic word_t fwdVal(fwdSel_t s, word_t regData);
        if (s == FWD_WB)
            return wResult();
        else if (s == FWD_MEM)
            return mAluR;
        return regData;
    endfunction

    task automatic calcExec();
        word_t srcA;
        srcA = fwdVal(eFwdA, eRd1);
        xWd = fwdVal(eFwdB, eRd2);
        xAlu = aluRef(eAlu, srcA, eAluSrc ? eImm : xWd);
        xZero = (xAlu == 0);
        xTaken = (eBr && (xZero ^ eF3[0])) || eJmp;
        xTarget = ePc + eImm;
    endtask

    task automatic resetModel();
        foreach (refRegs[i])
            refRegs[i] = 0;
        foreach (refMem[i])
            refMem[i] = 0;
        {eValid, eRegW, eMemW, eAluSrc, eBr, eJmp, eExp} = '0;
        {eRs1, eRs2, eRd, mRd, wRd, mRegW, mMemW, wRegW} = '0;
        eRes = RES_ALU;
        mRes = RES_ALU;
        wRes = RES_ALU;
        eAlu = ALU_ADD;
        eFwdA = FWD_RF;
        eFwdB = FWD_RF;
    endtask

    // one rising edge of the reference pipeline
    task automatic stepModel(row_t r);
        word_t rd1New, rd2New, readM;
        int idx;
        calcExec();
        rd1New = rfRead(r.rs1);
        rd2New = rfRead(r.rs2);
        idx = memIdx(mAluR);
        readM = refMem[idx];
        if (wRegW && wRd != 0)
            refRegs[wRd] = wResult();
        if (mMemW)
            refMem[idx] = mWd;
        {wAlu, wRead, wPc4, wRd, wRegW} = {mAluR, readM, mPc4, mRd, mRegW};
        wRes = mRes;
        {mAluR, mWd, mPc4, mRd, mRegW, mMemW} = {xAlu, xWd, ePc4, eRd, eRegW, eMemW};
        mRes = eRes;
        if (r.en) begin
            {ePc, ePc4, eRd1, eRd2, eImm, eF3} = {r.pc, r.pc + 32'd4, rd1New, rd2New, r.imm, r.f3};
        end
        if (r.flush) begin
            {eValid, eRs1, eRs2, eRd, eRegW, eMemW, eAluSrc, eBr, eJmp, eExp} = '0;
            eRes = RES_ALU;
            eAlu = ALU_ADD;
            eFwdA = FWD_RF;
            eFwdB = FWD_RF;
        end else if (r.en) begin
            {eValid, eRs1, eRs2, eRd, eRegW, eMemW} = {1'b1, r.rs1, r.rs2, r.rd, r.regW, r.memW};
            {eAluSrc, eBr, eJmp, eExp} = {r.aluSrc, r.br, r.jmp, r.expT};
            eRes = r.res;
            eAlu = r.alu;
            eFwdA = r.fa;
            eFwdB = r.fb;
        end
    endtask

    task automatic checkTags();
        checkVal("RdE_o", 32'(RdE_o), 32'(eRd));
        checkVal("Rs1E_o", 32'(Rs1E_o), 32'(eRs1));
        checkVal("Rs2E_o", 32'(Rs2E_o), 32'(eRs2));
        checkVal("RdM_o", 32'(RdM_o), 32'(mRd));
        checkVal("RdW_o", 32'(RdW_o), 32'(wRd));
        checkVal("a0_o", a0_o, refRegs[10]);
    endtask

    initial begin
        word_t r1, r2, r3;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        opRow(ALU_ADD, 1, 0, 0, 5, 1, FWD_RF, FWD_RF);
        opRow(ALU_ADD, 2, 0, 0, 12, 1, FWD_RF, FWD_RF);
        nopRow(1);
        nopRow(1);
        opRow(ALU_ADD, 10, 1, 2, 0, 0, FWD_RF, FWD_RF);
        opRow(ALU_SUB, 3, 2, 1, 0, 0, FWD_RF, FWD_RF);
        opRow(ALU_XOR, 10, 3, 1, 0, 0, FWD_MEM, FWD_RF);   // x3 one ahead
        opRow(ALU_OR, 4, 3, 10, 0, 0, FWD_WB, FWD_MEM);
        opRow(ALU_AND, 10, 4, 0, r1, 1, FWD_MEM, FWD_RF);
        opRow(ALU_SLL, 10, 1, 0, 4, 1, FWD_RF, FWD_RF);
        opRow(ALU_SRL, 10, 4, 0, 1, 1, FWD_RF, FWD_RF);
        opRow(ALU_SLT, 10, 3, 0, 32'hFFFF_FFFF, 1, FWD_RF, FWD_RF);
        opRow(ALU_SLT, 5, 1, 2, 0, 0, FWD_RF, FWD_RF);
        addRow(32'h40, 0, 2, 0, 8, ALU_ADD, 1, 0, 1, RES_ALU, 0, 0, 3'b010, 1, 0, 0);
        addRow(32'h44, 0, 3, 0, r2, ALU_ADD, 1, 0, 1, RES_ALU, 0, 0, 3'b010, 1, 0, 0);
        addRow(32'h48, 0, 0, 10, 8, ALU_ADD, 1, 1, 0, RES_MEM, 0, 0, 3'b010, 1, 0, 0);
        addRow(32'h4C, 0, 0, 10, r2, ALU_ADD, 1, 1, 0, RES_MEM, 0, 0, 3'b010, 1, 0, 0);
        // beq not taken, bne taken, beq taken, jal
        addRow(32'h100, 1, 2, 0, 16, ALU_SUB, 0, 0, 0, RES_ALU, 1, 0, 3'b000, 1, 0, 0);
        addRow(32'h104, 1, 2, 0, 32'hFFFF_FFF8, ALU_SUB, 0, 0, 0, RES_ALU, 1, 0, 3'b001, 1, 0, 1);
        addRow(32'h108, 2, 2, 0, r3, ALU_SUB, 0, 0, 0, RES_ALU, 1, 0, 3'b000, 1, 0, 1);
        addRow(32'h200, 0, 0, 10, 32, ALU_ADD, 0, 1, 0, RES_PC4, 0, 1, 3'b000, 1, 0, 1);
        addRow(32'h204, 0, 0, 10, 99, ALU_ADD, 1, 1, 0, RES_ALU, 0, 0, 3'b000, 1, 1, 0);
        addRow(32'h300, 1, 1, 0, 12, ALU_SUB, 0, 0, 0, RES_ALU, 1, 0, 3'b001, 1, 0, 0);
        nopRow(0); // bne held in execute
        nopRow(0);
        repeat (5) nopRow(1);
        cycleLimit = rows.size() + 5 + 20;

        clk = 0;
        rstN_i = 0;
        {pcD_i, extImmD_i, rs1D_i, rs2D_i, rdD_i, opcodeD_i, funct3D_i} = '0;
        {regWriteD_i, memWriteD_i, aluSrcD_i, branchD_i, jumpD_i, flushE_i} = '0;
        enD_i = 1;
        resultSrcD_i = RES_ALU;
        aluControlD_i = ALU_ADD;
        fwdAE_i = FWD_RF;
        fwdBE_i = FWD_RF;
        resetModel();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN_i = 1;
        #1;
        checkVal("pcSrcE_o", 32'(pcSrcE_o), 0);
        checkTags();

        foreach (rows[i]) begin
            @(negedge clk);
            {pcD_i, rs1D_i, rs2D_i, rdD_i, extImmD_i} =
                {rows[i].pc, rows[i].rs1, rows[i].rs2, rows[i].rd, rows[i].imm};
            {regWriteD_i, memWriteD_i, aluSrcD_i, branchD_i, jumpD_i} =
                {rows[i].regW, rows[i].memW, rows[i].aluSrc, rows[i].br, rows[i].jmp};
            funct3D_i = rows[i].f3;
            resultSrcD_i = rows[i].res;
            aluControlD_i = rows[i].alu;
            {enD_i, flushE_i} = {rows[i].en, rows[i].flush};
            fwdAE_i = eFwdA; // selects belong to the item now in execute
            fwdBE_i = eFwdB;
            #1;
            calcExec();
            checkVal("pcSrcE_o", 32'(pcSrcE_o), 32'(xTaken));
            checkVal("pcSrcE_o vs table", 32'(pcSrcE_o), 32'(eExp));
            if (eValid) begin
                checkVal("pcTargetE_o", pcTargetE_o, xTarget);
                checkVal("zeroE_o", 32'(zeroE_o), 32'(xZero));
            end
            @(posedge clk);
            stepModel(rows[i]);
            #1;
            checkTags();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: riscvExec.f
+incdir+include
verilog/riscDataPkg.sv
verilog/riscCtrlPkg.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/decodeExecReg.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/execPipeTop.sv
tests/execPipe_chk.sv
tests/execPipeTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = execPipeTb
FILELIST  = riscvExec.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
